//--- logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`default_nettype none

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Integer register file
`define NUM_REGS 32
`define REG_ZERO 5'd0

// Instruction field positions, used as instr[`FIELD]
`define FUNCT7 31:25
`define RS2    24:20
`define RS1    19:15
`define FUNCT3 14:12
`define RD     11:7
`define OPCODE 6:0

`default_nettype wire

`endif

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP_LUI      = 7'b0110111,
        OP_AUIPC    = 7'b0010111,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_BRANCH   = 7'b1100011,
        OP_LOAD     = 7'b0000011,
        OP_STORE    = 7'b0100011,
        OP_IMM      = 7'b0010011,
        OP_REG      = 7'b0110011,
        OP_MISC_MEM = 7'b0001111,
        OP_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        src_a_pc;
        logic        src_b_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        mem_to_reg;
        logic        branch;
        logic        jump;
        logic        jalr;
        logic [2:0]  funct3;
    } decode_t;

    typedef struct packed {
        logic        valid;
        decode_t     dec;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } ex_stage_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        mem_to_reg;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [31:0] store_data;
    } mem_stage_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        mem_to_reg;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [1:0]  offset;
    } wb_stage_t;

endpackage

`default_nettype wire

//--- logic/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  core_pkg::ex_stage_t ex,
    input  core_pkg::fwd_sel_e  fwd_a,
    input  core_pkg::fwd_sel_e  fwd_b,
    input  logic [31:0]         mem_result,
    input  logic [31:0]         wb_result,
    output logic [31:0]         alu_result,
    output logic [31:0]         store_data,
    output logic                redirect,
    output logic [31:0]         target
);
    logic [31:0] op_a, op_b;
    logic [31:0] alu_a, alu_b, alu_out;
    logic [31:0] target_sum;
    logic [4:0]  shamt;
    logic        taken;

    // Forwarded register operands
    assign op_a = (fwd_a == core_pkg::FWD_MEM) ? mem_result :
                  (fwd_a == core_pkg::FWD_WB)  ? wb_result  : ex.rs1_val;
    assign op_b = (fwd_b == core_pkg::FWD_MEM) ? mem_result :
                  (fwd_b == core_pkg::FWD_WB)  ? wb_result  : ex.rs2_val;

    assign alu_a = ex.dec.src_a_pc ? ex.pc : op_a;
    assign alu_b = ex.dec.src_b_imm ? ex.dec.imm : op_b;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (ex.dec.alu_op)
            core_pkg::ALU_SUB:    alu_out = alu_a - alu_b;
            core_pkg::ALU_SLL:    alu_out = alu_a << shamt;
            core_pkg::ALU_SLT:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::ALU_SLTU:   alu_out = {31'b0, alu_a < alu_b};
            core_pkg::ALU_XOR:    alu_out = alu_a ^ alu_b;
            core_pkg::ALU_SRL:    alu_out = alu_a >> shamt;
            core_pkg::ALU_SRA:    alu_out = $unsigned($signed(alu_a) >>> shamt);
            core_pkg::ALU_OR:     alu_out = alu_a | alu_b;
            core_pkg::ALU_AND:    alu_out = alu_a & alu_b;
            core_pkg::ALU_PASS_B: alu_out = alu_b;
            default:              alu_out = alu_a + alu_b;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (ex.dec.funct3)
            3'b000:  taken = op_a == op_b;
            3'b001:  taken = op_a != op_b;
            3'b100:  taken = $signed(op_a) < $signed(op_b);
            3'b101:  taken = $signed(op_a) >= $signed(op_b);
            3'b110:  taken = op_a < op_b;
            3'b111:  taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    assign target_sum = (ex.dec.jalr ? op_a : ex.pc) + ex.dec.imm;
    assign target = {target_sum[31:1], target_sum[0] & ~ex.dec.jalr};

    // Link address for JAL and JALR
    assign alu_result = ex.dec.jump ? ex.pc + 32'd4 : alu_out;
    assign store_data = op_b;
    assign redirect = ex.valid && (ex.dec.jump || (ex.dec.branch && taken));

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/1ns
`include "core_config.svh"
`default_nettype none

module hazard_unit (
    input  logic [4:0]         ex_rs1,
    input  logic [4:0]         ex_rs2,
    input  logic [4:0]         mem_rd,
    input  logic               mem_reg_write,
    input  logic [4:0]         wb_rd,
    input  logic               wb_reg_write,
    input  logic [4:0]         ex_rd,
    input  logic               ex_mem_read,
    input  logic [4:0]         dec_rs1,
    input  logic [4:0]         dec_rs2,
    input  logic               redirect,
    input  logic               instr_valid,
    input  logic               mem_access,
    input  logic               data_valid,
    output core_pkg::fwd_sel_e fwd_a,
    output core_pkg::fwd_sel_e fwd_b,
    output logic               fetch_stall,
    output logic               ex_bubble,
    output logic               pipe_freeze
);
    logic load_use;

    // Newest producer wins, x0 never forwards
    function automatic core_pkg::fwd_sel_e fwd_select(input logic [4:0] rs);
        if (rs == `REG_ZERO) begin
            return core_pkg::FWD_REG;
        end
        if (mem_reg_write && mem_rd == rs) begin
            return core_pkg::FWD_MEM;
        end
        if (wb_reg_write && wb_rd == rs) begin
            return core_pkg::FWD_WB;
        end
        return core_pkg::FWD_REG;
    endfunction

    assign fwd_a = fwd_select(ex_rs1);
    assign fwd_b = fwd_select(ex_rs2);

    assign load_use = ex_mem_read && ex_rd != `REG_ZERO &&
                      (ex_rd == dec_rs1 || ex_rd == dec_rs2);

    // A redirect discards the fetched instruction, so it never holds the PC
    assign fetch_stall = (load_use || !instr_valid) && !redirect;
    assign ex_bubble   = load_use || !instr_valid || redirect;
    assign pipe_freeze = mem_access && !data_valid;

endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`timescale 1ns/1ns
`include "core_config.svh"
`default_nettype none

module instr_decode (
    input  logic [31:0]       instr,
    output core_pkg::decode_t dec
);
    logic [31:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic              use_rs1, use_rs2;
    core_pkg::alu_op_e arith_op;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // SUB only exists in the register form
    always_comb begin
        case (instr[`FUNCT3])
            3'b000: arith_op = (instr[30] && instr[`OPCODE] == core_pkg::OP_REG)
                               ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001: arith_op = core_pkg::ALU_SLL;
            3'b010: arith_op = core_pkg::ALU_SLT;
            3'b011: arith_op = core_pkg::ALU_SLTU;
            3'b100: arith_op = core_pkg::ALU_XOR;
            3'b101: arith_op = instr[30] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: arith_op = core_pkg::ALU_OR;
            default: arith_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        dec.alu_op = core_pkg::ALU_ADD;
        dec.funct3 = instr[`FUNCT3];
        dec.rd = instr[`RD];
        case (instr[`OPCODE])
            core_pkg::OP_LUI: begin
                dec = '{default: '0, alu_op: core_pkg::ALU_PASS_B, imm: imm_u,
                       src_b_imm: 1'b1, reg_write: 1'b1, rd: instr[`RD],
                       funct3: instr[`FUNCT3]};
            end
            core_pkg::OP_AUIPC: begin
                dec.imm = imm_u;
                {dec.src_a_pc, dec.src_b_imm, dec.reg_write} = 3'b111;
            end
            core_pkg::OP_JAL: begin
                dec.imm = imm_j;
                {dec.reg_write, dec.jump} = 2'b11;
            end
            core_pkg::OP_JALR: begin
                dec.imm = imm_i;
                {dec.reg_write, dec.jump, dec.jalr} = 3'b111;
                use_rs1 = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                dec.imm = imm_b;
                dec.branch = 1'b1;
                {use_rs1, use_rs2} = 2'b11;
            end
            core_pkg::OP_LOAD: begin
                dec.imm = imm_i;
                {dec.src_b_imm, dec.reg_write, dec.mem_read, dec.mem_to_reg} = 4'b1111;
                use_rs1 = 1'b1;
            end
            core_pkg::OP_STORE: begin
                dec.imm = imm_s;
                {dec.src_b_imm, dec.mem_write} = 2'b11;
                {use_rs1, use_rs2} = 2'b11;
            end
            core_pkg::OP_IMM: begin
                dec.imm = imm_i;
                dec.alu_op = arith_op;
                {dec.src_b_imm, dec.reg_write} = 2'b11;
                use_rs1 = 1'b1;
            end
            core_pkg::OP_REG: begin
                dec.alu_op = arith_op;
                dec.reg_write = 1'b1;
                {use_rs1, use_rs2} = 2'b11;
            end
            // FENCE, SYSTEM and unknown opcodes retire as no-ops
            default: dec.rd = `REG_ZERO;
        endcase
        dec.rs1 = use_rs1 ? instr[`RS1] : `REG_ZERO;
        dec.rs2 = use_rs2 ? instr[`RS2] : `REG_ZERO;
        if (dec.rd == `REG_ZERO) begin
            dec.reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_align.sv
`timescale 1ns/1ns
`default_nettype none

module mem_align (
    input  logic [2:0]  funct3,
    input  logic [1:0]  offset,
    input  logic [31:0] wdata_in,
    output logic [31:0] wdata_out,
    output logic [3:0]  be,
    input  logic [31:0] rdata_in,
    output logic [31:0] rdata_out
);
    logic [31:0] lane;

    // Store lanes
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                wdata_out = {4{wdata_in[7:0]}};
                be = 4'b0001 << offset;
            end
            2'b01: begin
                wdata_out = {2{wdata_in[15:0]}};
                be = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_out = wdata_in;
                be = 4'b1111;
            end
        endcase
    end

    // Addressed lane moved to bit 0
    assign lane = rdata_in >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  rdata_out = {{24{lane[7]}}, lane[7:0]};
            3'b001:  rdata_out = {{16{lane[15]}}, lane[15:0]};
            3'b100:  rdata_out = {24'b0, lane[7:0]};
            3'b101:  rdata_out = {16'b0, lane[15:0]};
            default: rdata_out = rdata_in;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pipeline_core.sv
`timescale 1ns/1ns
`include "core_config.svh"
`default_nettype none

module pipeline_core (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] instr_addr,
    input  logic [31:0] instr_data,
    input  logic        instr_valid,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    output logic [3:0]  data_be,
    output logic        data_we,
    output logic        data_re,
    input  logic [31:0] data_rdata,
    input  logic        data_valid
);
    logic [31:0]          pc;
    logic [31:0]          regs [`NUM_REGS];
    core_pkg::decode_t    dec;
    core_pkg::ex_stage_t  ex_q, ex_d;
    core_pkg::mem_stage_t mem_q, mem_d;
    core_pkg::wb_stage_t  wb_q, wb_d;
    logic [31:0]          wb_rdata_q;
    core_pkg::fwd_sel_e   fwd_a, fwd_b;
    logic [31:0]          alu_result, store_data, target;
    logic [31:0]          load_data, wb_result;
    logic                 redirect, fetch_stall, ex_bubble, pipe_freeze;
    logic                 wb_write, mem_access;

    instr_decode u_instr_decode (
        .instr (instr_data),
        .dec   (dec)
    );

    execute_unit u_execute_unit (
        .ex         (ex_q),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (mem_q.alu_result),
        .wb_result  (wb_result),
        .alu_result (alu_result),
        .store_data (store_data),
        .redirect   (redirect),
        .target     (target)
    );

    hazard_unit u_hazard_unit (
        .ex_rs1        (ex_q.dec.rs1),
        .ex_rs2        (ex_q.dec.rs2),
        .mem_rd        (mem_q.rd),
        .mem_reg_write (mem_q.valid && mem_q.reg_write),
        .wb_rd         (wb_q.rd),
        .wb_reg_write  (wb_write),
        .ex_rd         (ex_q.dec.rd),
        .ex_mem_read   (ex_q.valid && ex_q.dec.mem_read),
        .dec_rs1       (dec.rs1),
        .dec_rs2       (dec.rs2),
        .redirect      (redirect),
        .instr_valid   (instr_valid),
        .mem_access    (mem_access),
        .data_valid    (data_valid),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fetch_stall   (fetch_stall),
        .ex_bubble     (ex_bubble),
        .pipe_freeze   (pipe_freeze)
    );

    mem_align u_store_align (
        .funct3    (mem_q.funct3),
        .offset    (mem_q.alu_result[1:0]),
        .wdata_in  (mem_q.store_data),
        .wdata_out (data_wdata),
        .be        (data_be),
        .rdata_in  (32'b0),
        .rdata_out ()
    );

    mem_align u_load_align (
        .funct3    (wb_q.funct3),
        .offset    (wb_q.offset),
        .wdata_in  (32'b0),
        .wdata_out (),
        .be        (),
        .rdata_in  (wb_rdata_q),
        .rdata_out (load_data)
    );

    assign wb_result  = wb_q.mem_to_reg ? load_data : wb_q.alu_result;
    assign wb_write   = wb_q.valid && wb_q.reg_write;
    assign mem_access = mem_q.valid && (mem_q.mem_read || mem_q.mem_write);

    // Register read sees the value being written back this cycle
    always_comb begin
        ex_d.valid   = !ex_bubble;
        ex_d.dec     = dec;
        ex_d.pc      = pc;
        ex_d.rs1_val = (wb_write && wb_q.rd == dec.rs1) ? wb_result : regs[dec.rs1];
        ex_d.rs2_val = (wb_write && wb_q.rd == dec.rs2) ? wb_result : regs[dec.rs2];
    end

    assign mem_d = '{valid: ex_q.valid, reg_write: ex_q.dec.reg_write,
                     mem_read: ex_q.dec.mem_read, mem_write: ex_q.dec.mem_write,
                     mem_to_reg: ex_q.dec.mem_to_reg, funct3: ex_q.dec.funct3,
                     rd: ex_q.dec.rd, alu_result: alu_result, store_data: store_data};

    assign wb_d = '{valid: mem_q.valid, reg_write: mem_q.reg_write,
                    mem_to_reg: mem_q.mem_to_reg, funct3: mem_q.funct3, rd: mem_q.rd,
                    alu_result: mem_q.alu_result, offset: mem_q.alu_result[1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_q.rd] <= wb_result;
        end
    end

    // Whole pipe holds while memory is not ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            ex_q.valid  <= 1'b0;
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else if (!pipe_freeze) begin
            if (redirect) begin
                pc <= target;
            end else if (!fetch_stall) begin
                pc <= pc + 32'd4;
            end
            ex_q       <= ex_d;
            mem_q      <= mem_d;
            wb_q       <= wb_d;
            wb_rdata_q <= data_rdata;
        end
    end

    assign instr_addr = pc;
    assign data_addr  = mem_q.alu_result;
    assign data_we    = mem_q.valid && mem_q.mem_write;
    assign data_re    = mem_q.valid && mem_q.mem_read;

    a_we_re_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_we && data_re));

    a_aligned_access: assert property (@(posedge clk) disable iff (!rst_n)
        mem_access |-> !((mem_q.funct3[1:0] == 2'b01 && data_addr[0]) ||
                         (mem_q.funct3[1:0] == 2'b10 && data_addr[1:0] != 2'b00)));

endmodule

`default_nettype wire

//--- tests/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    localparam logic [31:0] DATA_WORD   = 32'h8765_F0A5;
    localparam logic [31:0] POISON_ADDR = 32'h0000_00F0;
    localparam int          MAX_STORES  = 16;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        dropout_en;
    logic [31:0] instr_addr, instr_data;
    logic        instr_valid;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [3:0]  data_be;
    logic        data_we, data_re, data_valid;
    int          prog_len;

    logic [31:0] exp_addr [MAX_STORES];
    logic [31:0] exp_data [MAX_STORES];
    logic [3:0]  exp_be   [MAX_STORES];
    logic [31:0] cur_addr, cur_data;
    logic [3:0]  cur_be;
    logic        store_fire;
    int          num_expected;
    int          store_idx;
    int          mismatches = 0;
    int          other_errors = 0;
    int          timeouts = 0;

    always #5 clk = ~clk;

    pipeline_core u_pipeline_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .instr_valid (instr_valid),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_be     (data_be),
        .data_we     (data_we),
        .data_re     (data_re),
        .data_rdata  (data_rdata),
        .data_valid  (data_valid)
    );

    tb_memory #(.DATA_WORD(DATA_WORD), .SEED(32'h3616)) u_memory (
        .clk         (clk),
        .dropout_en  (dropout_en),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .instr_valid (instr_valid),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_be     (data_be),
        .data_we     (data_we),
        .data_rdata  (data_rdata),
        .data_valid  (data_valid),
        .prog_len    (prog_len)
    );

    task automatic add_expected(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be);
        exp_addr[num_expected] = addr;
        exp_data[num_expected] = data;
        exp_be[num_expected]   = be;
        num_expected++;
    endtask

    // Register values follow the program in tb_memory
    task automatic build_expected_stores();
        logic [31:0] x2, x3, x4, x5, x6, x7, x8, x9, x10, x11, x12, x14, x16;
        logic [31:0] byte_s, half_s;
        x2  = 32'd5;
        x3  = x2 + 32'd7;
        x4  = x3 + x2;
        x5  = x4 - x3;
        x6  = x4 << 3;
        x7  = x6 ^ x5;
        x8  = {20'hFFFFF, 12'h000};
        x9  = $signed(x8) >>> 4;
        x10 = x8 >> 28;
        x11 = {31'b0, $signed(x8) < $signed(x2)};
        x12 = x9 | x10;
        // AUIPC sits at 0x38
        x14 = 32'h38 + {20'h00001, 12'h000};
        x16 = x14 + x2;
        byte_s = {{24{DATA_WORD[15]}}, DATA_WORD[15:8]};
        half_s = {{16{DATA_WORD[31]}}, DATA_WORD[31:16]};
        num_expected = 0;
        add_expected(32'h100, x4, 4'hF);
        add_expected(32'h104, x7, 4'hF);
        add_expected(32'h108, x12, 4'hF);
        // x0 reads as zero
        add_expected(32'h10C, 32'd0 + x11, 4'hF);
        add_expected(32'h110, x14, 4'hF);
        add_expected(32'h114, x16, 4'hF);
        // Link of the JAL at 0x64
        add_expected(32'h118, 32'h64 + 32'd4, 4'hF);
        add_expected(32'h11D, {4{byte_s[7:0]}}, 4'b0010);
        add_expected(32'h11E, {2{half_s[15:0]}}, 4'b1100);
        add_expected(32'h120, {24'b0, DATA_WORD[15:8]}, 4'hF);
        add_expected(32'h124, {16'b0, DATA_WORD[31:16]}, 4'hF);
        add_expected(32'h128, x2, 4'hF);
        // Sign bits of lb and lh
        add_expected(32'h12C, byte_s, 4'hF);
        add_expected(32'h130, half_s, 4'hF);
    endtask

    task automatic run_program(input logic with_dropout);
        @(posedge clk);
        rst_n      <= 1'b0;
        dropout_en <= with_dropout;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (store_idx < num_expected) begin
            @(posedge clk);
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d mismatches, %0d other, %0d timeouts",
                 mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    assign store_fire = data_we && data_valid;

    always_comb begin
        cur_addr = exp_addr[store_idx % MAX_STORES];
        cur_data = exp_data[store_idx % MAX_STORES];
        cur_be   = exp_be[store_idx % MAX_STORES];
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            store_idx <= 0;
        end else if (store_fire) begin
            store_idx <= store_idx + 1;
        end
    end

    a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire && store_idx < num_expected |->
            data_addr == cur_addr && data_wdata == cur_data && data_be == cur_be)
    else begin
        mismatches++;
        $display("MISMATCH data_addr %h exp %h data_wdata %h exp %h data_be %h exp %h",
                 $sampled(data_addr), $sampled(cur_addr), $sampled(data_wdata),
                 $sampled(cur_data), $sampled(data_be), $sampled(cur_be));
    end

    a_no_extra_store: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> store_idx < num_expected)
    else begin
        other_errors++;
        $display("Store at address %h came after the last expected store", $sampled(data_addr));
    end

    a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
        data_we |-> data_addr != POISON_ADDR)
    else begin
        other_errors++;
        $display("An instruction that should have been skipped stored to the poison address");
    end

    a_we_re_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_we && data_re))
    else begin
        other_errors++;
        $display("data_we and data_re were high in the same cycle");
    end

    initial begin
        rst_n      <= 1'b0;
        dropout_en <= 1'b0;
        build_expected_stores();
        run_program(1'b0);
        // Same program again, with valid dropout
        run_program(1'b1);
        report_and_finish();
    end

    initial begin
        #1;
        repeat (40 * prog_len) @(posedge clk);
        timeouts++;
        $display("Watchdog expired after %0d cycles with %0d of %0d stores seen in this run",
                 40 * prog_len, store_idx, num_expected);
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- tests/tb_memory.sv
`timescale 1ns/1ns
`default_nettype none

module tb_memory #(
    parameter logic [31:0] DATA_WORD = 32'h0,
    parameter int unsigned SEED      = 0
) (
    input  logic        clk,
    input  logic        dropout_en,
    input  logic [31:0] instr_addr,
    output logic [31:0] instr_data,
    output logic        instr_valid,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    input  logic [3:0]  data_be,
    input  logic        data_we,
    output logic [31:0] data_rdata,
    output logic        data_valid,
    output int          prog_len
);
    localparam logic [6:0]  OPI        = 7'b0010011;
    localparam logic [6:0]  LOAD       = 7'b0000011;
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam int          PROG_WORDS = 41;

    logic [31:0] rom [64];
    logic [31:0] ram [256];

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
        end
        // Fill value carries the byte address
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'hA500_0000 ^ (i * 4);
        end
        ram[32'h200 >> 2] = DATA_WORD;
        // ALU chain, x1 is the results base
        rom[0]  = i_type(12'd256, 5'd0, 3'b000, 5'd1, OPI);
        rom[1]  = i_type(12'd5, 5'd0, 3'b000, 5'd2, OPI);
        rom[2]  = i_type(12'd7, 5'd2, 3'b000, 5'd3, OPI);
        rom[3]  = r_type(7'h00, 5'd2, 5'd3, 3'b000, 5'd4);
        rom[4]  = r_type(7'h20, 5'd3, 5'd4, 3'b000, 5'd5);
        rom[5]  = i_type(12'd3, 5'd4, 3'b001, 5'd6, OPI);
        rom[6]  = r_type(7'h00, 5'd5, 5'd6, 3'b100, 5'd7);
        rom[7]  = u_type(20'hFFFFF, 5'd8, 7'b0110111);
        rom[8]  = i_type(12'h404, 5'd8, 3'b101, 5'd9, OPI);
        rom[9]  = i_type(12'd28, 5'd8, 3'b101, 5'd10, OPI);
        rom[10] = r_type(7'h00, 5'd2, 5'd8, 3'b010, 5'd11);
        rom[11] = r_type(7'h00, 5'd10, 5'd9, 3'b110, 5'd12);
        rom[12] = i_type(12'd9, 5'd2, 3'b000, 5'd0, OPI);
        rom[13] = r_type(7'h00, 5'd11, 5'd0, 3'b000, 5'd13);
        rom[14] = u_type(20'h00001, 5'd14, 7'b0010111);
        rom[15] = s_type(12'd0, 5'd4, 5'd1, 3'b010);
        rom[16] = s_type(12'd4, 5'd7, 5'd1, 3'b010);
        rom[17] = s_type(12'd8, 5'd12, 5'd1, 3'b010);
        rom[18] = s_type(12'd12, 5'd13, 5'd1, 3'b010);
        rom[19] = s_type(12'd16, 5'd14, 5'd1, 3'b010);
        // Load then dependent add
        rom[20] = i_type(12'd16, 5'd1, 3'b010, 5'd15, LOAD);
        rom[21] = r_type(7'h00, 5'd2, 5'd15, 3'b000, 5'd16);
        rom[22] = s_type(12'd20, 5'd16, 5'd1, 3'b010);
        // Taken beq and jal each skip a store to x1 - 16
        rom[23] = b_type(13'd8, 5'd5, 5'd2, 3'b000);
        rom[24] = s_type(12'hFF0, 5'd2, 5'd1, 3'b010);
        rom[25] = j_type(21'd8, 5'd17);
        rom[26] = s_type(12'hFF0, 5'd2, 5'd1, 3'b010);
        rom[27] = s_type(12'd24, 5'd17, 5'd1, 3'b010);
        // Sub-word loads from 0x200, then sb and sh
        rom[28] = i_type(12'd512, 5'd0, 3'b000, 5'd18, OPI);
        rom[29] = i_type(12'd1, 5'd18, 3'b000, 5'd19, LOAD);
        rom[30] = i_type(12'd1, 5'd18, 3'b100, 5'd20, LOAD);
        rom[31] = i_type(12'd2, 5'd18, 3'b001, 5'd21, LOAD);
        rom[32] = i_type(12'd2, 5'd18, 3'b101, 5'd22, LOAD);
        rom[33] = s_type(12'd29, 5'd19, 5'd1, 3'b000);
        rom[34] = s_type(12'd30, 5'd21, 5'd1, 3'b001);
        rom[35] = s_type(12'd32, 5'd20, 5'd1, 3'b010);
        rom[36] = s_type(12'd36, 5'd22, 5'd1, 3'b010);
        rom[37] = s_type(12'd40, 5'd2, 5'd1, 3'b010);
        // Full words of the signed loads
        rom[38] = s_type(12'd44, 5'd19, 5'd1, 3'b010);
        rom[39] = s_type(12'd48, 5'd21, 5'd1, 3'b010);
        rom[40] = j_type(21'd0, 5'd0);
    end

    assign instr_data = rom[instr_addr[7:2]];
    assign data_rdata = ram[data_addr[9:2]];
    assign prog_len   = PROG_WORDS;

    always @(posedge clk) begin
        if (data_we && data_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (data_be[b]) begin
                    ram[data_addr[9:2]][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

    // About one cycle in four drops out when enabled
    initial begin
        instr_valid <= 1'b0;
        data_valid  <= 1'b0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            instr_valid <= !dropout_en || ($urandom % 4 != 0);
            data_valid  <= !dropout_en || ($urandom % 4 != 0);
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/core_pkg.sv
logic/instr_decode.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/mem_align.sv
logic/pipeline_core.sv
tests/tb_memory.sv
tests/core_tb.sv
